/* include/xfcp_consts.svh */
`ifndef XFCP_CONSTS_SVH
`define XFCP_CONSTS_SVH

// Number of RAM nodes behind the switch
`define XFCP_PORTS 4

// Word address width of each node RAM
`define XFCP_RAM_AW 8

// Wishbone data width
`define XFCP_WB_DW 32

// Request opcodes
// The reply carries the opcode plus one
`define XFCP_OP_READ 8'h10
`define XFCP_OP_WRITE 8'h12

`endif

/* verilog/xfcp_pkg.sv */
`include "xfcp_consts.svh"

package xfcp_pkg;

    typedef logic [7:0] xfcp_byte_t;
    typedef logic [$clog2(`XFCP_PORTS)-1:0] port_idx_t;
    typedef logic [`XFCP_RAM_AW-1:0] wb_addr_t;
    typedef logic [`XFCP_WB_DW-1:0] wb_data_t;
    typedef logic [7:0] word_cnt_t;

    typedef enum logic [1:0] {
        SW_IDLE,
        SW_FORWARD,
        SW_DROP
    } switch_state_e;

    typedef enum logic [2:0] {
        MW_HEADER,
        MW_WRITE_DATA,
        MW_BUS_CYCLE,
        MW_REPLY_HEADER,
        MW_REPLY_DATA,
        MW_DROP
    } mod_wb_state_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_PORT_BYTE,
        ARB_PASS
    } arb_state_e;

endpackage

/* verilog/xfcp_stream_if.sv */
`timescale 1ns/10ps

// Byte stream with valid/ready/last handshake
interface xfcp_stream_if;

    logic [7:0] tdata;
    logic       tvalid;
    logic       tready;
    logic       tlast;

    modport src (
        output tdata, tvalid, tlast,
        input  tready
    );

    modport dst (
        input  tdata, tvalid, tlast,
        output tready
    );

endinterface

/* verilog/wb_if.sv */
`timescale 1ns/10ps
`include "xfcp_consts.svh"

interface wb_if;

    logic [`XFCP_RAM_AW-1:0] adr;
    logic [`XFCP_WB_DW-1:0]  dat_w;
    logic [`XFCP_WB_DW-1:0]  dat_r;
    logic                    we;
    logic                    stb;
    logic                    cyc;
    logic                    ack;

    modport master (output adr, dat_w, we, stb, cyc, input dat_r, ack);

    modport slave (input adr, dat_w, we, stb, cyc, output dat_r, ack);

endinterface

/* verilog/xfcp_switch.sv */
`timescale 1ns/10ps
`include "xfcp_consts.svh"

module xfcp_switch
    import xfcp_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  xfcp_byte_t  up_in_tdata_i,
    input  logic        up_in_tvalid_i,
    input  logic        up_in_tlast_i,
    output logic        up_in_tready_o,
    xfcp_stream_if.src  down_o [`XFCP_PORTS]
);

    switch_state_e          state;
    port_idx_t              sel;
    xfcp_byte_t             out_data;
    logic                   out_last;
    logic                   out_valid;
    logic [`XFCP_PORTS-1:0] down_ready;
    logic [`XFCP_PORTS-1:0] down_valid;
    logic                   in_xfer;

    for (genvar g = 0; g < `XFCP_PORTS; g++) begin : g_down
        assign down_valid[g]   = out_valid && (sel == g);
        assign down_o[g].tvalid = down_valid[g];
        assign down_o[g].tdata  = out_data;
        assign down_o[g].tlast  = out_last;
        assign down_ready[g]    = down_o[g].tready;
    end

    // Hold off a new port byte until the last byte of the old packet has left
    always_comb begin
        case (state)
            SW_IDLE:    up_in_tready_o = !out_valid;
            SW_FORWARD: up_in_tready_o = !out_valid || down_ready[sel];
            default:    up_in_tready_o = 1'b1;
        endcase
    end

    assign in_xfer = up_in_tvalid_i && up_in_tready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state     <= SW_IDLE;
            sel       <= '0;
            out_valid <= 1'b0;
        end else begin
            if (out_valid && down_ready[sel]) begin
                out_valid <= 1'b0;
            end
            case (state)
                SW_IDLE: begin
                    if (in_xfer && !up_in_tlast_i) begin
                        if (up_in_tdata_i < `XFCP_PORTS) begin
                            sel   <= port_idx_t'(up_in_tdata_i);
                            state <= SW_FORWARD;
                        end else begin
                            state <= SW_DROP;
                        end
                    end
                end
                SW_FORWARD: begin
                    if (in_xfer) begin
                        out_valid <= 1'b1;
                        if (up_in_tlast_i) begin
                            state <= SW_IDLE;
                        end
                    end
                end
                default: begin
                    if (in_xfer && up_in_tlast_i) begin
                        state <= SW_IDLE;
                    end
                end
            endcase
        end
    end

    // Skid register payload
    always_ff @(posedge clk_i) begin
        if (state == SW_FORWARD && in_xfer) begin
            out_data <= up_in_tdata_i;
            out_last <= up_in_tlast_i;
        end
    end

    // A stalled byte stays on the same node
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        out_valid && !down_ready[sel] |=> out_valid && $stable(sel) && $stable(out_data));

endmodule

/* verilog/xfcp_mod_wb.sv */
`timescale 1ns/10ps
`include "xfcp_consts.svh"

module xfcp_mod_wb
    import xfcp_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    xfcp_stream_if.dst req_i,
    xfcp_stream_if.src rsp_o,
    wb_if.master       wb_o
);

    mod_wb_state_e state;
    logic [1:0]    hdr_idx;
    logic [1:0]    byte_idx;
    word_cnt_t     word_idx;
    xfcp_byte_t    opcode;
    wb_addr_t      addr;
    word_cnt_t     count;
    wb_data_t      wdata;
    wb_data_t      rdata;
    logic          req_last;
    logic          req_xfer;
    logic          rsp_xfer;
    logic          is_write;
    logic          op_known;
    logic          has_wdata;
    logic          last_word;

    assign is_write  = (opcode == `XFCP_OP_WRITE);
    assign op_known  = (req_i.tdata == `XFCP_OP_READ) || (req_i.tdata == `XFCP_OP_WRITE);
    // Only meaningful on the count byte
    assign has_wdata = is_write && (req_i.tdata != '0);
    assign last_word = (word_idx == count - 8'd1);

    assign req_i.tready = (state == MW_HEADER) || (state == MW_WRITE_DATA) ||
                          (state == MW_DROP);
    assign req_xfer = req_i.tvalid && req_i.tready;

    assign rsp_o.tvalid = (state == MW_REPLY_HEADER) || (state == MW_REPLY_DATA);
    assign rsp_xfer     = rsp_o.tvalid && rsp_o.tready;

    always_comb begin
        if (state == MW_REPLY_DATA) begin
            rsp_o.tdata = rdata[{byte_idx, 3'b000} +: 8];
            rsp_o.tlast = (byte_idx == 2'd3) && (word_idx == count);
        end else begin
            case (hdr_idx)
                2'd0:    rsp_o.tdata = opcode + 8'd1;
                2'd1:    rsp_o.tdata = xfcp_byte_t'(addr);
                default: rsp_o.tdata = count;
            endcase
            rsp_o.tlast = (hdr_idx == 2'd2) && (is_write || count == '0);
        end
    end

    // Word address wraps at the RAM size
    assign wb_o.adr   = addr + wb_addr_t'(word_idx);
    assign wb_o.dat_w = wdata;
    assign wb_o.we    = is_write;
    assign wb_o.stb   = (state == MW_BUS_CYCLE);
    assign wb_o.cyc   = (state == MW_BUS_CYCLE);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state    <= MW_HEADER;
            hdr_idx  <= '0;
            byte_idx <= '0;
            word_idx <= '0;
        end else begin
            case (state)
                MW_HEADER: begin
                    if (req_xfer) begin
                        hdr_idx  <= hdr_idx + 2'd1;
                        byte_idx <= '0;
                        word_idx <= '0;
                        if (hdr_idx == 2'd0 && !op_known) begin
                            hdr_idx <= '0;
                            if (!req_i.tlast) begin
                                state <= MW_DROP;
                            end
                        end else if (hdr_idx == 2'd2) begin
                            hdr_idx <= '0;
                            if (req_i.tlast) begin
                                state <= has_wdata ? MW_HEADER : MW_REPLY_HEADER;
                            end else begin
                                state <= has_wdata ? MW_WRITE_DATA : MW_DROP;
                            end
                        end else if (req_i.tlast) begin
                            hdr_idx <= '0;
                        end
                    end
                end
                MW_WRITE_DATA: begin
                    if (req_xfer) begin
                        byte_idx <= byte_idx + 2'd1;
                        if (byte_idx == 2'd3) begin
                            state <= MW_BUS_CYCLE;
                        end else if (req_i.tlast) begin
                            state <= MW_HEADER;
                        end
                    end
                end
                MW_BUS_CYCLE: begin
                    if (wb_o.ack) begin
                        word_idx <= word_idx + 8'd1;
                        if (!is_write) begin
                            state <= MW_REPLY_DATA;
                        end else if (last_word) begin
                            state <= req_last ? MW_REPLY_HEADER : MW_DROP;
                        end else begin
                            state <= req_last ? MW_HEADER : MW_WRITE_DATA;
                        end
                    end
                end
                MW_REPLY_HEADER: begin
                    if (rsp_xfer) begin
                        hdr_idx <= hdr_idx + 2'd1;
                        if (hdr_idx == 2'd2) begin
                            hdr_idx <= '0;
                            state   <= (!is_write && count != '0) ? MW_BUS_CYCLE : MW_HEADER;
                        end
                    end
                end
                MW_REPLY_DATA: begin
                    if (rsp_xfer) begin
                        byte_idx <= byte_idx + 2'd1;
                        if (byte_idx == 2'd3) begin
                            state <= (word_idx == count) ? MW_HEADER : MW_BUS_CYCLE;
                        end
                    end
                end
                default: begin
                    if (req_xfer && req_i.tlast) begin
                        state <= MW_HEADER;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == MW_HEADER && req_xfer) begin
            case (hdr_idx)
                2'd0:    opcode <= req_i.tdata;
                2'd1:    addr   <= wb_addr_t'(req_i.tdata);
                default: count  <= req_i.tdata;
            endcase
        end
        // Little endian word assembly
        if (state == MW_WRITE_DATA && req_xfer) begin
            wdata[{byte_idx, 3'b000} +: 8] <= req_i.tdata;
            req_last <= req_i.tlast;
        end
        if (state == MW_BUS_CYCLE && wb_o.ack && !is_write) begin
            rdata <= wb_o.dat_r;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $fell(wb_o.stb) |-> $past(wb_o.ack));

endmodule

/* verilog/wb_ram.sv */
`timescale 1ns/10ps

module wb_ram
    import xfcp_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,
    wb_if.slave   wb_i
);

    wb_data_t mem [2**$bits(wb_addr_t)];
    logic     req;

    // Second half of a cycle is the ack itself
    assign req = wb_i.stb && wb_i.cyc && !wb_i.ack;

    always_ff @(posedge clk_i) begin
        if (req && wb_i.we) begin
            mem[wb_i.adr] <= wb_i.dat_w;
        end
        wb_i.dat_r <= mem[wb_i.adr];
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_i.ack <= 1'b0;
        end else begin
            wb_i.ack <= req;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_i.ack |-> wb_i.stb && wb_i.cyc);

endmodule

/* verilog/xfcp_arb.sv */
`timescale 1ns/10ps
`include "xfcp_consts.svh"

module xfcp_arb
    import xfcp_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    xfcp_stream_if.dst  up_i [`XFCP_PORTS],
    output xfcp_byte_t  up_out_tdata_o,
    output logic        up_out_tvalid_o,
    output logic        up_out_tlast_o,
    input  logic        up_out_tready_i
);

    arb_state_e             state;
    port_idx_t              grant;
    port_idx_t              next_grant;
    logic                   any_valid;
    logic [`XFCP_PORTS-1:0] up_valid;
    logic [`XFCP_PORTS-1:0] up_last;
    xfcp_byte_t             up_data [`XFCP_PORTS];
    logic                   out_xfer;

    for (genvar g = 0; g < `XFCP_PORTS; g++) begin : g_up
        assign up_valid[g]    = up_i[g].tvalid;
        assign up_last[g]     = up_i[g].tlast;
        assign up_data[g]     = up_i[g].tdata;
        assign up_i[g].tready = (state == ARB_PASS) && (grant == g) && up_out_tready_i;
    end

    // Scan downwards so the port right after the last winner wins
    always_comb begin
        next_grant = grant;
        any_valid  = 1'b0;
        for (int k = `XFCP_PORTS; k >= 1; k--) begin
            if (up_valid[port_idx_t'(grant + k)]) begin
                next_grant = port_idx_t'(grant + k);
                any_valid  = 1'b1;
            end
        end
    end

    always_comb begin
        up_out_tvalid_o = 1'b0;
        up_out_tdata_o  = xfcp_byte_t'(grant);
        up_out_tlast_o  = 1'b0;
        case (state)
            ARB_PORT_BYTE: up_out_tvalid_o = 1'b1;
            ARB_PASS: begin
                up_out_tvalid_o = up_valid[grant];
                up_out_tdata_o  = up_data[grant];
                up_out_tlast_o  = up_last[grant];
            end
            default: ;
        endcase
    end

    assign out_xfer = up_out_tvalid_o && up_out_tready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= ARB_IDLE;
            grant <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (any_valid) begin
                        grant <= next_grant;
                        state <= ARB_PORT_BYTE;
                    end
                end
                ARB_PORT_BYTE: if (out_xfer) state <= ARB_PASS;
                default: if (out_xfer && up_out_tlast_o) state <= ARB_IDLE;
            endcase
        end
    end

    // Nodes must hold their byte while the host stalls
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        up_out_tvalid_o && !up_out_tready_i |=> up_out_tvalid_o && $stable(up_out_tdata_o));

endmodule

/* verilog/xfcp_core.sv */
`timescale 1ns/10ps
`include "xfcp_consts.svh"

module xfcp_core
    import xfcp_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,

    // Host request stream
    input  xfcp_byte_t  up_in_tdata_i,
    input  logic        up_in_tvalid_i,
    input  logic        up_in_tlast_i,
    output logic        up_in_tready_o,

    // Host reply stream
    output xfcp_byte_t  up_out_tdata_o,
    output logic        up_out_tvalid_o,
    output logic        up_out_tlast_o,
    input  logic        up_out_tready_i
);

    xfcp_stream_if req_if [`XFCP_PORTS] ();
    xfcp_stream_if rsp_if [`XFCP_PORTS] ();

    xfcp_switch i_xfcp_switch (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .up_in_tdata_i  (up_in_tdata_i),
        .up_in_tvalid_i (up_in_tvalid_i),
        .up_in_tlast_i  (up_in_tlast_i),
        .up_in_tready_o (up_in_tready_o),
        .down_o         (req_if)
    );

    // One Wishbone RAM node per switch port
    for (genvar g = 0; g < `XFCP_PORTS; g++) begin : g_node
        wb_if wb ();

        xfcp_mod_wb i_xfcp_mod_wb (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .req_i   (req_if[g]),
            .rsp_o   (rsp_if[g]),
            .wb_o    (wb)
        );

        wb_ram i_wb_ram (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .wb_i    (wb)
        );
    end

    xfcp_arb i_xfcp_arb (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .up_i            (rsp_if),
        .up_out_tdata_o  (up_out_tdata_o),
        .up_out_tvalid_o (up_out_tvalid_o),
        .up_out_tlast_o  (up_out_tlast_o),
        .up_out_tready_i (up_out_tready_i)
    );

endmodule

/* tests/tb_xfcp_core.sv */
`timescale 1ns/10ps
`include "xfcp_consts.svh"

module tb_xfcp_core
    import xfcp_pkg::*;
();

    logic       clk;
    logic       rst_n;
    xfcp_byte_t up_in_tdata;
    logic       up_in_tvalid;
    logic       up_in_tlast;
    logic       up_in_tready;
    xfcp_byte_t up_out_tdata;
    logic       up_out_tvalid;
    logic       up_out_tlast;
    logic       up_out_tready;

    wb_data_t   shadow [`XFCP_PORTS][2**`XFCP_RAM_AW];
    xfcp_byte_t exp_q [`XFCP_PORTS][$];
    int         exp_len [`XFCP_PORTS][$];
    xfcp_byte_t req_q [$];
    int         pending;
    int         traffic;
    int         errors;
    bit         ready_random;
    int         rx_idx;
    int         rx_port;
    int         rx_len;
    wb_data_t   rx_word;
    wb_data_t   exp_word;

    xfcp_core i_xfcp_core (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .up_in_tdata_i   (up_in_tdata),
        .up_in_tvalid_i  (up_in_tvalid),
        .up_in_tlast_i   (up_in_tlast),
        .up_in_tready_o  (up_in_tready),
        .up_out_tdata_o  (up_out_tdata),
        .up_out_tvalid_o (up_out_tvalid),
        .up_out_tlast_o  (up_out_tlast),
        .up_out_tready_i (up_out_tready)
    );

    always #50 clk = ~clk;

    task automatic check_byte(input string name, input xfcp_byte_t exp, input xfcp_byte_t got);
        if (got !== exp) begin
            $display("ERR %0t %s expected %02h got %02h", $time, name, exp, got);
            $display("=== FAIL ===");
            $fatal(1, "byte mismatch");
        end
    endtask

    task automatic check_word(input string name, input wb_data_t exp, input wb_data_t got);
        if (got !== exp) begin
            $display("ERR %0t %s expected %08h got %08h", $time, name, exp, got);
            $display("=== FAIL ===");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_last(input string name, input bit exp, input bit got);
        if (got !== exp) begin
            $display("ERR %0t %s expected %0b got %0b", $time, name, exp, got);
            $display("=== FAIL ===");
            $fatal(1, "tlast mismatch");
        end
    endtask

    // Expected reply bytes go to the queue of the addressed port
    function automatic void model_reply();
        xfcp_byte_t port;
        xfcp_byte_t op;
        wb_addr_t   addr;
        word_cnt_t  cnt;
        wb_data_t   w;
        int         p;
        port = req_q[0];
        op   = req_q[1];
        addr = req_q[2];
        cnt  = req_q[3];
        if (port >= `XFCP_PORTS || (op != `XFCP_OP_READ && op != `XFCP_OP_WRITE)) begin
            return;
        end
        p = port;
        exp_q[p].push_back(port);
        exp_q[p].push_back(op + 8'd1);
        exp_q[p].push_back(addr);
        exp_q[p].push_back(cnt);
        for (int i = 0; i < cnt; i++) begin
            if (op == `XFCP_OP_WRITE) begin
                w = {req_q[7 + 4*i], req_q[6 + 4*i], req_q[5 + 4*i], req_q[4 + 4*i]};
                shadow[p][wb_addr_t'(addr + i)] = w;
            end else begin
                w = shadow[p][wb_addr_t'(addr + i)];
                for (int k = 0; k < 4; k++) begin
                    exp_q[p].push_back(w[8*k +: 8]);
                end
            end
        end
        exp_len[p].push_back(op == `XFCP_OP_READ ? 4 + 4*cnt : 4);
        traffic += exp_len[p][$];
        pending++;
    endfunction

    // Starts and ends on a falling edge
    task automatic send_byte(input xfcp_byte_t b, input bit last);
        bit done;
        up_in_tdata  = b;
        up_in_tvalid = 1'b1;
        up_in_tlast  = last;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            done = up_in_tready;
            @(negedge clk);
        end
        up_in_tvalid = 1'b0;
        up_in_tlast  = 1'b0;
    endtask

    task automatic issue_request(input xfcp_byte_t port, input xfcp_byte_t op,
                                 input wb_addr_t addr, input word_cnt_t cnt);
        wb_data_t w;
        req_q.delete();
        req_q.push_back(port);
        req_q.push_back(op);
        req_q.push_back(addr);
        req_q.push_back(cnt);
        if (op == `XFCP_OP_WRITE) begin
            for (int i = 0; i < cnt; i++) begin
                w = $urandom;
                for (int k = 0; k < 4; k++) begin
                    req_q.push_back(w[8*k +: 8]);
                end
            end
        end
        model_reply();
        traffic += req_q.size();
        for (int i = 0; i < req_q.size(); i++) begin
            send_byte(req_q[i], i == req_q.size() - 1);
        end
    endtask

    task automatic wait_idle();
        wait (pending == 0);
        repeat (4) @(negedge clk);
    endtask

    always @(negedge clk) begin
        if (ready_random) begin
            up_out_tready = ($urandom % 2) == 0;
        end else begin
            up_out_tready = 1'b1;
        end
    end

    // Reply order is checked per port
    always @(posedge clk) begin
        if (rst_n && up_out_tvalid && up_out_tready) begin
            if (rx_idx == 0) begin
                rx_port = up_out_tdata;
                if (rx_port >= `XFCP_PORTS || exp_len[rx_port].size() == 0) begin
                    $display("Reply for port %0d arrived with no request outstanding", rx_port);
                    $display("=== FAIL ===");
                    $fatal(1, "unexpected reply");
                end
                rx_len = exp_len[rx_port].pop_front();
                void'(exp_q[rx_port].pop_front());
            end else if (rx_idx < 4) begin
                check_byte("up_out_tdata_o", exp_q[rx_port].pop_front(), up_out_tdata);
            end else begin
                rx_word[8*((rx_idx - 4) % 4) +: 8] = up_out_tdata;
                if ((rx_idx - 4) % 4 == 3) begin
                    exp_word = {exp_q[rx_port][3], exp_q[rx_port][2],
                                exp_q[rx_port][1], exp_q[rx_port][0]};
                    repeat (4) void'(exp_q[rx_port].pop_front());
                    check_word("up_out_tdata_o word", exp_word, rx_word);
                end
            end
            check_last("up_out_tlast_o", rx_idx == rx_len - 1, up_out_tlast);
            if (rx_idx == rx_len - 1) begin
                rx_idx = 0;
                pending--;
            end else begin
                rx_idx++;
            end
        end
    end

    // Limit grows with the bytes sent and expected
    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= 2 * traffic * 20 + 200) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, no reply arrived for %0d requests", cycles, pending);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    initial begin
        xfcp_byte_t port;
        xfcp_byte_t op;
        void'($urandom(32'hf418902f));
        clk           = 1'b0;
        rst_n         = 1'b0;
        up_in_tdata   = '0;
        up_in_tvalid  = 1'b0;
        up_in_tlast   = 1'b0;
        up_out_tready = 1'b1;
        ready_random  = 1'b0;
        pending       = 0;
        traffic       = 0;
        errors        = 0;
        rx_idx        = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Fill every RAM, then read all of it back
        for (int p = 0; p < `XFCP_PORTS; p++) begin
            for (int b = 0; b < 4; b++) begin
                issue_request(xfcp_byte_t'(p), `XFCP_OP_WRITE, wb_addr_t'(b * 64), 8'd64);
            end
        end
        for (int p = 0; p < `XFCP_PORTS; p++) begin
            for (int b = 0; b < 4; b++) begin
                issue_request(xfcp_byte_t'(p), `XFCP_OP_READ, wb_addr_t'(b * 64), 8'd64);
            end
        end
        wait_idle();

        // Neighbours of port 1 keep their data
        issue_request(8'd1, `XFCP_OP_WRITE, 8'd16, 8'd8);
        for (int p = 0; p < `XFCP_PORTS; p++) begin
            issue_request(xfcp_byte_t'(p), `XFCP_OP_READ, 8'd0, 8'd32);
        end
        wait_idle();

        issue_request(8'd5, `XFCP_OP_READ, 8'd0, 8'd2);
        issue_request(8'd3, `XFCP_OP_READ, 8'd8, 8'd2);
        wait_idle();

        issue_request(8'd2, 8'h33, 8'd4, 8'd2);
        issue_request(8'd2, `XFCP_OP_READ, 8'd4, 8'd2);
        wait_idle();

        ready_random = 1'b1;
        for (int n = 0; n < 16; n++) begin
            port = xfcp_byte_t'($urandom % `XFCP_PORTS);
            op   = ($urandom % 2) ? `XFCP_OP_READ : `XFCP_OP_WRITE;
            issue_request(port, op, wb_addr_t'($urandom), word_cnt_t'(1 + $urandom % 8));
        end

        // Across the top of the address space
        issue_request(8'd0, `XFCP_OP_WRITE, 8'd250, 8'd12);
        issue_request(8'd0, `XFCP_OP_READ, 8'd250, 8'd12);
        issue_request(8'd0, `XFCP_OP_READ, 8'd0, 8'd6);
        wait_idle();
        ready_random = 1'b0;

        repeat (50) @(negedge clk);
        if (up_out_tvalid) begin
            $display("Reply traffic still present after the last request was answered");
            errors++;
        end
        if (errors == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("=== FAIL ===");
            $fatal(1, "end of run check failed");
        end
    end

endmodule

/* flist.f */
+incdir+include
verilog/xfcp_pkg.sv
verilog/xfcp_stream_if.sv
verilog/wb_if.sv
verilog/xfcp_switch.sv
verilog/xfcp_mod_wb.sv
verilog/wb_ram.sv
verilog/xfcp_arb.sv
verilog/xfcp_core.sv
tests/tb_xfcp_core.sv

/* Bender.yml */
package:
  name: xfcp_core

export_include_dirs:
  - include

sources:
  - verilog/xfcp_pkg.sv
  - verilog/xfcp_stream_if.sv
  - verilog/wb_if.sv
  - verilog/xfcp_switch.sv
  - verilog/xfcp_mod_wb.sv
  - verilog/wb_ram.sv
  - verilog/xfcp_arb.sv
  - verilog/xfcp_core.sv
  - target: test
    files:
      - tests/tb_xfcp_core.sv
